// File: files.f
+incdir+hdl
+incdir+verification
hdl/mipsPkg.sv
hdl/pipeRegs.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/execStage.sv
hdl/mulSeqCtrl.sv
hdl/cycleTimer.sv
hdl/hazardUnit.sv
hdl/miniMipsCore.sv
verification/miniMipsTb.sv

// File: hdl/cycleTimer.sv
`timescale 1ns/1ps
`default_nettype none

module cycleTimer (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       load,
    input  wire logic [3:0] loadValue,
    output logic            timerDone
);
    logic [3:0] count;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= loadValue;
        end else if (count != '0) begin
            count <= count - 4'd1;
        end
    end

    assign timerDone = count == '0;

    noEarlyReload: assert property (@(posedge clk) disable iff (reset)
        load |-> count == '0);
endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module decodeStage import mipsPkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire fetchData_t                dataF,
    input  wire logic                      wbWrite,
    input  wire logic [`MIPS_REG_BITS-1:0] wbReg,
    input  wire logic [`MIPS_XLEN-1:0]     wbValue,
    output decodeData_t                    dataDNew
);
    logic [`MIPS_XLEN-1:0]     regs [`MIPS_NREGS];
    logic [5:0]                opField;
    logic [5:0]                funct;
    logic [15:0]               imm16;
    logic [`MIPS_REG_BITS-1:0] rs;
    logic [`MIPS_REG_BITS-1:0] rt;
    opcode_t                   op;

    assign opField = dataF.instr[31:26];
    assign funct = dataF.instr[5:0];
    assign imm16 = dataF.instr[15:0];
    assign rs = dataF.instr[25:21];
    assign rt = dataF.instr[20:16];

    always_comb begin
        op = OP_NOP;
        case (opField)
            6'h00: begin
                case (funct)
                    6'h21: op = OP_ADDU;
                    6'h23: op = OP_SUBU;
                    6'h24: op = OP_AND;
                    6'h25: op = OP_OR;
                    6'h2a: op = OP_SLT;
                    default: op = OP_NOP;
                endcase
            end
            6'h1c: op = (funct == 6'h02) ? OP_MUL : OP_NOP;    // special2.
            6'h09: op = OP_ADDIU;
            6'h0d: op = OP_ORI;
            6'h0f: op = OP_LUI;
            6'h04: op = OP_BEQ;
            default: op = OP_NOP;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite && wbReg != '0) begin
            regs[wbReg] <= wbValue;
        end
    end

    function automatic logic [`MIPS_XLEN-1:0] readReg(input logic [`MIPS_REG_BITS-1:0] r);
        if (r == '0) begin
            return '0;
        end
        if (wbWrite && wbReg == r) begin
            return wbValue;    // write-through.
        end
        return regs[r];
    endfunction

    always_comb begin
        dataDNew.pc = dataF.pc;
        dataDNew.op = op;
        dataDNew.rs = rs;
        dataDNew.rt = rt;
        dataDNew.rd = (opField == 6'h00 || opField == 6'h1c) ? dataF.instr[15:11] : rt;
        dataDNew.rsVal = readReg(rs);
        dataDNew.rtVal = readReg(rt);
        case (op)
            OP_ORI: dataDNew.imm = {16'h0, imm16};
            OP_LUI: dataDNew.imm = {imm16, 16'h0};
            default: dataDNew.imm = {{16{imm16[15]}}, imm16};
        endcase
        dataDNew.valid = dataF.valid;
    end

    zeroNeverWritten: assert property (@(posedge clk) disable iff (reset)
        wbWrite |-> wbReg != '0);
endmodule

`default_nettype wire

// File: hdl/execStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module execStage import mipsPkg::*; (
    input  wire decodeData_t               dataD,
    input  wire logic [1:0]                fwdA,
    input  wire logic [1:0]                fwdB,
    input  wire logic [`MIPS_XLEN-1:0]     memResult,
    input  wire logic [`MIPS_XLEN-1:0]     wbResult,
    output logic [`MIPS_XLEN-1:0]          execResult,
    output execData_t                      dataENew,
    output logic                           branchTaken,
    output logic [31:0]                    branchTarget,
    output logic [`MIPS_REG_BITS-1:0]      rs,
    output logic [`MIPS_REG_BITS-1:0]      rt,
    output logic                           isMul,
    output logic [`MIPS_XLEN-1:0]          opA,
    output logic [`MIPS_XLEN-1:0]          opB
);
    always_comb begin
        case (fwdA)
            2'b01: opA = memResult;
            2'b10: opA = wbResult;
            default: opA = dataD.rsVal;
        endcase
        case (fwdB)
            2'b01: opB = memResult;
            2'b10: opB = wbResult;
            default: opB = dataD.rtVal;
        endcase
    end

    always_comb begin
        case (dataD.op)
            OP_ADDU: execResult = opA + opB;
            OP_SUBU: execResult = opA - opB;
            OP_AND: execResult = opA & opB;
            OP_OR: execResult = opA | opB;
            OP_SLT: execResult = {31'h0, $signed(opA) < $signed(opB)};
            OP_MUL: execResult = opA * opB;    // low word only.
            OP_ADDIU: execResult = opA + dataD.imm;
            OP_ORI: execResult = opA | dataD.imm;
            OP_LUI: execResult = dataD.imm;
            default: execResult = '0;
        endcase
    end

    assign branchTaken = dataD.valid && dataD.op == OP_BEQ && opA == opB;
    assign branchTarget = dataD.pc + 32'd4 + {dataD.imm[29:0], 2'b00};
    assign rs = dataD.rs;
    assign rt = dataD.rt;
    assign isMul = dataD.op == OP_MUL;

    assign dataENew.pc = dataD.pc;
    assign dataENew.result = execResult;
    assign dataENew.rd = dataD.rd;
    assign dataENew.writes = dataD.valid && dataD.op != OP_BEQ && dataD.op != OP_NOP
                             && dataD.rd != '0;
    assign dataENew.valid = dataD.valid;
endmodule

`default_nettype wire

// File: hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module fetchStage import mipsPkg::*; (
    input  wire logic                        clk,
    input  wire logic                        run,
    input  wire logic [31:0]                 pc,
    input  wire logic                        branchTaken,
    input  wire logic [31:0]                 branchTarget,
    input  wire logic                        imemWrite,
    input  wire logic [`MIPS_IMEM_ABITS-1:0] imemAddr,
    input  wire logic [31:0]                 imemData,
    output logic [31:0]                      pcNext,
    output fetchData_t                       dataFNew
);
    logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (imemWrite && !run) begin
            imem[imemAddr] <= imemData;    // loaded only while stopped.
        end
    end

    assign pcNext = branchTaken ? branchTarget : pc + 32'd4;

    assign dataFNew.pc = pc;
    assign dataFNew.instr = imem[pc[`MIPS_IMEM_ABITS+1:2]];
    assign dataFNew.valid = run;
endmodule

`default_nettype wire

// File: hdl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module hazardUnit (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      run,
    input  wire logic                      mulHold,
    input  wire logic                      branchTaken,
    input  wire logic [`MIPS_REG_BITS-1:0] rsE,
    input  wire logic [`MIPS_REG_BITS-1:0] rtE,
    input  wire logic [`MIPS_REG_BITS-1:0] rdM,
    input  wire logic                      writesM,
    input  wire logic [`MIPS_REG_BITS-1:0] rdW,
    input  wire logic                      writesW,
    output logic [1:0]                     fwdA,
    output logic [1:0]                     fwdB,
    output logic                           stallF,
    output logic                           stallD,
    output logic                           stallE,
    output logic                           stallM,
    output logic                           flushD,
    output logic                           flushE,
    output logic                           flushM,
    output logic                           flushW
);
    function automatic logic [1:0] fwdSel(input logic [`MIPS_REG_BITS-1:0] src);
        if (src == '0) begin
            return 2'b00;
        end
        if (writesM && rdM == src) begin
            return 2'b01;    // newest wins.
        end
        if (writesW && rdW == src) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    assign fwdA = fwdSel(rsE);
    assign fwdB = fwdSel(rtE);

    // a branch resolving as run drops still redirects the pc.
    assign stallF = mulHold || (!run && !branchTaken);
    assign stallD = mulHold;
    assign stallE = mulHold;
    assign stallM = 1'b0;
    assign flushD = branchTaken || !run;
    assign flushE = branchTaken;
    assign flushM = mulHold;
    assign flushW = 1'b0;

    noBranchInHold: assert property (@(posedge clk) disable iff (reset)
        !(branchTaken && mulHold));
endmodule

`default_nettype wire

// File: hdl/miniMipsCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module miniMipsCore import mipsPkg::*; (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        run,
    input  wire logic                        imemWrite,
    input  wire logic [`MIPS_IMEM_ABITS-1:0] imemAddr,
    input  wire logic [31:0]                 imemData,
    output logic                             wbValid,
    output logic [`MIPS_REG_BITS-1:0]        wbReg,
    output logic [`MIPS_XLEN-1:0]            wbValue,
    output logic [31:0]                      wbPc
);
    logic [31:0] pc, pcNext, branchTarget;
    logic [31:0] opA, opB;
    logic [1:0] fwdA, fwdB;
    logic [4:0] rsE, rtE;
    logic branchTaken, isMul, timerLoad, timerDone, mulHold;
    logic stallF, stallD, stallE, stallM, flushD, flushE, flushM, flushW;
    fetchData_t dataFNew, dataF;
    decodeData_t dataDNew, dataD;
    execData_t dataENew, dataE;
    memData_t dataM;

    assign wbValid = dataM.valid && dataM.writes && dataM.rd != '0;
    assign wbReg = dataM.rd;
    assign wbValue = dataM.result;
    assign wbPc = dataM.pc;

    fReg i_fReg (.clk, .reset, .stallF, .pcNext, .pc);
    fetchStage i_fetchStage (.clk, .run, .pc, .branchTaken, .branchTarget, .imemWrite,
        .imemAddr, .imemData, .pcNext, .dataFNew);
    dReg i_dReg (.clk, .reset, .stallD, .flushD, .dataFNew, .dataF);
    decodeStage i_decodeStage (.clk, .reset, .dataF, .wbWrite(wbValid), .wbReg, .wbValue,
        .dataDNew);
    eReg i_eReg (.clk, .reset, .stallE, .flushE, .mulHold, .rsFwd(opA), .rtFwd(opB),
        .dataDNew, .dataD);
    execStage i_execStage (.dataD, .fwdA, .fwdB, .memResult(dataE.result),
        .wbResult(dataM.result), .execResult(), .dataENew, .branchTaken, .branchTarget,
        .rs(rsE), .rt(rtE), .isMul, .opA, .opB);
    mReg i_mReg (.clk, .reset, .stallM, .flushM, .dataENew, .dataE);
    wReg i_wReg (.clk, .reset, .flushW, .dataMNew(dataE), .dataM);

    // hold covers the first cycle, so the timer counts the rest.
    mulSeqCtrl i_mulSeqCtrl (.clk, .reset, .isMul, .validE(dataD.valid), .timerDone,
        .timerLoad, .mulHold);
    cycleTimer i_cycleTimer (.clk, .reset, .load(timerLoad),
        .loadValue(4'(`MIPS_MUL_LATENCY - 3)), .timerDone);

    hazardUnit i_hazardUnit (.clk, .reset, .run, .mulHold, .branchTaken, .rsE, .rtE,
        .rdM(dataE.rd), .writesM(dataE.writes), .rdW(dataM.rd), .writesW(dataM.writes),
        .fwdA, .fwdB, .stallF, .stallD, .stallE, .stallM, .flushD, .flushE, .flushM,
        .flushW);
endmodule

`default_nettype wire

// File: hdl/mipsPkg.sv
`default_nettype none
`include "mips_consts.svh"

package mipsPkg;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADDU  = 4'd1,
        OP_SUBU  = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_SLT   = 4'd5,
        OP_MUL   = 4'd6,
        OP_ADDIU = 4'd7,
        OP_ORI   = 4'd8,
        OP_LUI   = 4'd9,
        OP_BEQ   = 4'd10
    } opcode_t;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_BUSY = 2'd1,
        MUL_DONE = 2'd2
    } mulState_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] pc;
        logic [`MIPS_XLEN-1:0] instr;
        logic                  valid;
    } fetchData_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]     pc;
        opcode_t                   op;
        logic [`MIPS_REG_BITS-1:0] rs;
        logic [`MIPS_REG_BITS-1:0] rt;
        logic [`MIPS_REG_BITS-1:0] rd;    // destination, rt for immediates.
        logic [`MIPS_XLEN-1:0]     rsVal;
        logic [`MIPS_XLEN-1:0]     rtVal;
        logic [`MIPS_XLEN-1:0]     imm;   // already extended.
        logic                      valid;
    } decodeData_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]     pc;
        logic [`MIPS_XLEN-1:0]     result;
        logic [`MIPS_REG_BITS-1:0] rd;
        logic                      writes;
        logic                      valid;
    } execData_t;

    typedef execData_t memData_t;

endpackage

`default_nettype wire

// File: hdl/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_XLEN 32
`define MIPS_NREGS 32
`define MIPS_REG_BITS 5
`define MIPS_IMEM_DEPTH 64
`define MIPS_IMEM_ABITS 6
`define MIPS_MUL_LATENCY 4

`endif

// File: hdl/mulSeqCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module mulSeqCtrl import mipsPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic isMul,
    input  wire logic validE,
    input  wire logic timerDone,
    output logic      timerLoad,
    output logic      mulHold
);
    mulState_t state;
    mulState_t stateNext;
    logic      start;

    assign start = state == MUL_IDLE && isMul && validE;
    assign timerLoad = start;
    assign mulHold = start || state == MUL_BUSY;

    always_comb begin
        stateNext = state;
        case (state)
            MUL_IDLE: if (start) stateNext = MUL_BUSY;
            MUL_BUSY: if (timerDone) stateNext = MUL_DONE;
            MUL_DONE: stateNext = MUL_IDLE;    // same mul leaves now.
            default: stateNext = MUL_IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= MUL_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    mulStaysInExec: assert property (@(posedge clk) disable iff (reset)
        state != MUL_IDLE |-> isMul && validE);
endmodule

`default_nettype wire

// File: hdl/pipeRegs.sv
`timescale 1ns/1ps
`default_nettype none

// shared stall / flush register, stall wins over flush.
module stageReg #(
    parameter type packetT = logic
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   stall,
    input  wire logic   flush,
    input  wire packetT dNew,
    output packetT      q
);
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (!stall && flush) begin
            q <= '0;    // bubble.
        end else if (!stall) begin
            q <= dNew;
        end
    end
endmodule

module fReg (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        stallF,
    input  wire logic [31:0] pcNext,
    output logic [31:0]      pc
);
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (!stallF) begin
            pc <= pcNext;
        end
    end
endmodule

module dReg import mipsPkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       stallD,
    input  wire logic       flushD,
    input  wire fetchData_t dataFNew,
    output fetchData_t      dataF
);
    stageReg #(.packetT(fetchData_t)) i_stageReg (
        .clk(clk), .reset(reset), .stall(stallD), .flush(flushD),
        .dNew(dataFNew), .q(dataF)
    );
endmodule

module eReg import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        stallE,
    input  wire logic        flushE,
    input  wire logic        mulHold,
    input  wire logic [31:0] rsFwd,
    input  wire logic [31:0] rtFwd,
    input  wire decodeData_t dataDNew,
    output decodeData_t      dataD
);
    decodeData_t held;
    decodeData_t nextD;

    // a held packet picks up forwarded operands before the producer drains.
    always_comb begin
        held = dataD;
        held.rsVal = rsFwd;
        held.rtVal = rtFwd;
        nextD = stallE ? held : dataDNew;
    end

    stageReg #(.packetT(decodeData_t)) i_stageReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flushE),
        .dNew(nextD), .q(dataD)
    );

    stallFlushExclusive: assert property (@(posedge clk) disable iff (reset)
        !mulHold |-> !(flushE && stallE));
endmodule

module mReg import mipsPkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      stallM,
    input  wire logic      flushM,
    input  wire execData_t dataENew,
    output execData_t      dataE
);
    stageReg #(.packetT(execData_t)) i_stageReg (
        .clk(clk), .reset(reset), .stall(stallM), .flush(flushM),
        .dNew(dataENew), .q(dataE)
    );
endmodule

module wReg import mipsPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     flushW,
    input  wire memData_t dataMNew,
    output memData_t      dataM
);
    stageReg #(.packetT(memData_t)) i_stageReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flushW),
        .dNew(dataMNew), .q(dataM)
    );
endmodule

`default_nettype wire

// File: verification/miniMipsProgram.svh
`ifndef MINI_MIPS_PROGRAM_SVH
`define MINI_MIPS_PROGRAM_SVH

localparam logic [5:0] opcSpecial = 6'h00;
localparam logic [5:0] opcSpecial2 = 6'h1c;
localparam logic [5:0] opcAddiu = 6'h09;
localparam logic [5:0] opcOri = 6'h0d;
localparam logic [5:0] opcLui = 6'h0f;
localparam logic [5:0] opcBeq = 6'h04;
localparam logic [5:0] fnAddu = 6'h21;
localparam logic [5:0] fnSubu = 6'h23;
localparam logic [5:0] fnAnd = 6'h24;
localparam logic [5:0] fnOr = 6'h25;
localparam logic [5:0] fnSlt = 6'h2a;
localparam logic [5:0] fnMul = 6'h02;

task automatic emitR(input logic [5:0] opField, input logic [5:0] funct,
                     input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
    prog.push_back({opField, rs, rt, rd, 5'h00, funct});
endtask

task automatic emitI(input logic [5:0] opField, input logic [4:0] rt,
                     input logic [4:0] rs, input logic [15:0] imm);
    prog.push_back({opField, rs, rt, imm});
endtask

task automatic loadConst(input logic [4:0] r);
    logic [31:0] value;
    value = $random(seed);
    emitI(opcLui, r, 5'd0, value[31:16]);
    emitI(opcOri, r, r, value[15:0]);
endtask

// branch to itself, ends every program.
task automatic emitHalt();
    emitI(opcBeq, 5'd0, 5'd0, 16'hffff);
endtask

task automatic buildAluProgram();
    prog.delete();
    for (int r = 1; r <= 4; r++) begin
        loadConst(5'(r));
    end
    emitR(opcSpecial, fnAddu, 5, 1, 2);
    emitR(opcSpecial, fnSubu, 6, 5, 3);    // distance one.
    emitR(opcSpecial, fnAnd, 7, 5, 4);     // distance two.
    emitR(opcSpecial, fnOr, 8, 6, 7);
    emitR(opcSpecial, fnSlt, 9, 1, 2);
    emitR(opcSpecial, fnSlt, 10, 2, 1);
    emitI(opcAddiu, 11, 8, 16'h8001);
    emitI(opcOri, 12, 11, 16'hbeef);
    emitI(opcLui, 13, 0, 16'h1234);
    emitR(opcSpecial, fnAddu, 0, 1, 2);    // r0 stays zero.
    emitI(opcAddiu, 0, 13, 16'h0005);
    emitR(opcSpecial, fnAddu, 14, 0, 13);
    emitR(opcSpecial, 6'h3f, 15, 1, 2);    // unknown funct.
    emitR(opcSpecial, fnOr, 16, 0, 0);
    emitHalt();
endtask

task automatic buildBranchProgram();
    prog.delete();
    loadConst(1);
    emitR(opcSpecial, fnOr, 2, 1, 0);
    emitI(opcBeq, 2, 1, 16'd2);            // taken on a forwarded operand.
    emitI(opcAddiu, 3, 0, 16'd7);
    emitI(opcAddiu, 4, 0, 16'd8);
    emitI(opcAddiu, 5, 0, 16'd3);
    emitI(opcAddiu, 5, 5, 16'hffff);       // loop head.
    emitR(opcSpecial, fnAddu, 6, 6, 5);
    emitI(opcBeq, 0, 5, 16'd1);            // loop exit.
    emitI(opcBeq, 0, 0, 16'hfffc);         // back to loop head.
    emitI(opcBeq, 1, 0, 16'd3);            // not taken.
    emitI(opcAddiu, 7, 6, 16'd1);
    emitI(opcAddiu, 8, 7, 16'd1);
    emitHalt();
endtask

task automatic buildMulProgram();
    prog.delete();
    for (int r = 1; r <= 3; r++) begin
        loadConst(5'(r));
    end
    emitR(opcSpecial2, fnMul, 4, 1, 2);
    emitR(opcSpecial, fnAddu, 5, 4, 3);    // needs the product.
    emitR(opcSpecial2, fnMul, 6, 4, 5);
    emitR(opcSpecial2, fnMul, 7, 6, 6);
    emitR(opcSpecial, fnSubu, 8, 7, 1);
    emitI(opcBeq, 8, 8, 16'd1);
    emitR(opcSpecial2, fnMul, 9, 1, 1);
    emitR(opcSpecial, fnAnd, 10, 8, 2);
    emitHalt();
endtask

`endif

// File: verification/miniMipsTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module miniMipsTb;
    logic        clk;
    logic        reset;
    logic        run;
    logic        imemWrite;
    logic [5:0]  imemAddr;
    logic [31:0] imemData;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbValue;
    logic [31:0] wbPc;

    logic [31:0] prog [$];
    logic [31:0] expPcQ [$];
    logic [4:0]  expRegQ [$];
    logic [31:0] expValQ [$];
    logic        headValid;
    logic [31:0] headPc;
    logic [4:0]  headReg;
    logic [31:0] headVal;
    logic        stopped;
    integer      seed = 41;
    int          errorCount;
    int          cycle;
    int          watchStart;
    int          watchLimit;

    `include "miniMipsProgram.svh"

    miniMipsCore i_dut (.clk, .reset, .run, .imemWrite, .imemAddr, .imemData,
        .wbValid, .wbReg, .wbValue, .wbPc);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failRun(input string what);
        $display("%s", what);
        errorCount++;
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string formatMismatch(input string name, input logic [31:0] expected,
                                              input logic [31:0] actual);
        return $sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
    endfunction

    // unused words hold no-ops tagged with their address.
    function automatic logic [31:0] fillWord(input int addr);
        return {6'h3f, 20'h0, 6'(addr)};
    endfunction

    task automatic refreshHead();
        headValid = expPcQ.size() > 0;
        if (headValid) begin
            headPc = expPcQ[0];
            headReg = expRegQ[0];
            headVal = expValQ[0];
        end
    endtask

    // sequential ISA model, queues every write to a non-zero register.
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] value;
        logic [4:0]  dest;
        logic        writes;
        int          steps;
        regs = '{default: '0};
        pc = '0;
        for (steps = 0; steps < 1000; steps++) begin
            instr = prog[pc[31:2]];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            sext = {{16{instr[15]}}, instr[15:0]};
            dest = instr[20:16];
            writes = 1'b1;
            value = '0;
            case (instr[31:26])
                opcSpecial: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        fnAddu: value = a + b;
                        fnSubu: value = a - b;
                        fnAnd: value = a & b;
                        fnOr: value = a | b;
                        fnSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                opcSpecial2: begin
                    dest = instr[15:11];
                    writes = instr[5:0] == fnMul;
                    value = a * b;
                end
                opcAddiu: value = a + sext;
                opcOri: value = a | {16'h0, instr[15:0]};
                opcLui: value = {instr[15:0], 16'h0};
                default: writes = 1'b0;    // beq and unknown encodings.
            endcase
            if (writes && dest != 5'd0) begin
                regs[dest] = value;
                expPcQ.push_back(pc);
                expRegQ.push_back(dest);
                expValQ.push_back(value);
            end
            if (instr[31:26] == opcBeq && a == b) begin
                if (sext == 32'hffff_ffff) begin
                    break;    // halt loop.
                end
                pc = pc + 32'd4 + (sext << 2);
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic runProgram(input bit withPause);
        watchLimit = 4 * (prog.size() + 20) * `MIPS_MUL_LATENCY;
        watchStart = cycle;
        run <= 1'b0;
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int addr = 0; addr < `MIPS_IMEM_DEPTH; addr++) begin
            @(posedge clk);
            imemWrite <= 1'b1;
            imemAddr <= 6'(addr);
            imemData <= (addr < prog.size()) ? prog[addr] : fillWord(addr);
        end
        @(posedge clk);
        imemWrite <= 1'b0;
        runModel();
        refreshHead();
        run <= 1'b1;
        if (withPause) begin
            repeat (14) @(posedge clk);
            run <= 1'b0;
            repeat (8) @(posedge clk);    // drain, mul included.
            stopped <= 1'b1;
            repeat (6) @(posedge clk);
            stopped <= 1'b0;
            run <= 1'b1;
        end
        while (headValid) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);    // nothing more may retire.
    endtask

    always @(posedge clk) begin
        if (!reset && wbValid && headValid) begin
            void'(expPcQ.pop_front());
            void'(expRegQ.pop_front());
            void'(expValQ.pop_front());
            refreshHead();
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle - watchStart > watchLimit) begin
            failRun("watchdog expired because the program did not finish");
        end
    end

    retireExpected: assert property (@(posedge clk) disable iff (reset)
        wbValid |-> headValid)
        else failRun("wbValid pulsed although no retirement was expected");
    pcMatches: assert property (@(posedge clk) disable iff (reset)
        wbValid && headValid |-> wbPc == headPc)
        else failRun(formatMismatch("wbPc", $sampled(headPc), $sampled(wbPc)));
    regMatches: assert property (@(posedge clk) disable iff (reset)
        wbValid && headValid |-> wbReg == headReg)
        else failRun(formatMismatch("wbReg", 32'($sampled(headReg)), 32'($sampled(wbReg))));
    valueMatches: assert property (@(posedge clk) disable iff (reset)
        wbValid && headValid |-> wbValue == headVal)
        else failRun(formatMismatch("wbValue", $sampled(headVal), $sampled(wbValue)));
    quietWhileStopped: assert property (@(posedge clk) disable iff (reset)
        stopped |-> !wbValid)
        else failRun("a result retired while run was low after the pipeline drained");

    initial begin
        reset = 1'b1;
        run = 1'b0;
        imemWrite = 1'b0;
        imemAddr = '0;
        imemData = '0;
        stopped = 1'b0;
        headValid = 1'b0;
        errorCount = 0;
        cycle = 0;
        watchStart = 0;
        watchLimit = 4 * (`MIPS_IMEM_DEPTH + 20) * `MIPS_MUL_LATENCY;
        buildAluProgram();
        runProgram(1'b1);
        buildBranchProgram();
        runProgram(1'b0);
        buildMulProgram();
        runProgram(1'b0);
        if (errorCount == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "simulation stopped");
        end
    end
endmodule

`default_nettype wire
